//--- hw/cpu_pkg.sv
package cpu_pkg;

  localparam int NUM_CTX = 4;       // resident process slots
  localparam int NUM_REGS = 8;      // registers per slot
  localparam int NUM_LPAGES = 4;    // logical pages per process
  localparam int PAGE_WORDS = 64;
  localparam int PAGE_BITS = $clog2(PAGE_WORDS);
  localparam int RAM_WORDS = 1024;
  localparam int SLICE_LEN = 3;     // instructions per time slice

  typedef logic [15:0] data_t;      // ram word, register, immediate
  typedef logic [9:0] paddr_t;      // physical ram address
  typedef logic [7:0] laddr_t;      // logical process address
  typedef logic [1:0] ctx_t;
  typedef logic [2:0] reg_idx_t;
  typedef logic [1:0] lpage_t;
  typedef logic [3:0] ppage_t;

  // instruction word is {opcode, register}, followed by one immediate word
  typedef enum logic [7:0] {
    JMP       = 8'd1,
    RAM2REG   = 8'd2,
    REG2RAM   = 8'd3,
    NUM2REG   = 8'd4,
    REG_PLUS  = 8'd5,
    REG_MINUS = 8'd6,
    EXIT      = 8'd17
  } opcode_t;

  typedef enum logic [2:0] {
    IDLE,       // wait for work, switch context
    XLATE,      // translate pc
    READ,       // read opcode word, translate pc + 1
    FETCH_OP,   // latch opcode word, read immediate
    FETCH_IMM,  // latch immediate
    DECODE,     // execute or start data access
    LOAD_DATA,  // ram2reg translate and read
    STORE       // reg2ram write
  } exec_state_t;

endpackage

//--- hw/dual_port_ram.sv
module dual_port_ram
  import cpu_pkg::*;
(
  input  logic   clka,
  input  logic   we,
  input  paddr_t waddr,
  input  data_t  wdata,
  input  paddr_t raddr,
  output data_t  rdata
);

  data_t mem [RAM_WORDS];

  always_ff @(posedge clka) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read data follows the address by one cycle
  always_ff @(posedge clka) begin
    rdata <= mem[raddr];
  end

endmodule

//--- hw/mmu_xlate.sv
module mmu_xlate
  import cpu_pkg::*;
(
  input  logic   clka,
  input  logic   rst_n,
  input  logic   map_we,
  input  ctx_t   map_ctx,
  input  lpage_t map_lpage,
  input  ppage_t map_ppage,
  input  logic   xlate_req,
  input  ctx_t   xlate_ctx,
  input  laddr_t xlate_laddr,
  output logic   xlate_done,
  output paddr_t xlate_paddr,
  output logic   xlate_fault
);

  localparam int NUM_ENTRIES = NUM_CTX * NUM_LPAGES;

  logic [NUM_ENTRIES-1:0] valid;
  ppage_t                 ppage_tab [NUM_ENTRIES];
  lpage_t                 req_lpage;
  logic [3:0]             req_entry;
  logic [3:0]             map_entry;

  assign req_lpage = xlate_laddr[7:PAGE_BITS];
  assign req_entry = {xlate_ctx, req_lpage};  // table is indexed by {ctx, page}
  assign map_entry = {map_ctx, map_lpage};

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (map_we) begin
      valid[map_entry] <= 1'b1;
    end
  end

  always_ff @(posedge clka) begin
    if (map_we) begin
      ppage_tab[map_entry] <= map_ppage;
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
    end else begin
      xlate_done  <= xlate_req;
      xlate_fault <= xlate_req & ~valid[req_entry];  // unmapped page
    end
  end

  always_ff @(posedge clka) begin
    if (xlate_req) begin
      xlate_paddr <= {ppage_tab[req_entry], xlate_laddr[PAGE_BITS-1:0]};  // page * 64 + offset
    end
  end

endmodule

//--- hw/proc_context.sv
module proc_context
  import cpu_pkg::*;
#(
  parameter int CTX_ID = 0
) (
  input  logic               clka,
  input  logic               rst_n,
  input  logic               start,
  input  logic [NUM_CTX-1:0] start_mask,
  input  logic               ctx_we,
  input  ctx_t               ctx_sel,
  input  logic               reg_we,
  input  reg_idx_t           reg_idx,
  input  data_t              reg_wdata,
  input  logic               pc_we,
  input  laddr_t             pc_wdata,
  input  logic               kill,
  output logic               active,
  output laddr_t             pc,
  output data_t              regs [NUM_REGS]
);

  logic launch;
  logic hit;

  assign launch = start & start_mask[CTX_ID];
  assign hit    = ctx_we & active & (ctx_sel == ctx_t'(CTX_ID));  // only a live slot takes writes

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      pc     <= '0;
    end else if (launch) begin
      active <= 1'b1;
      pc     <= '0;  // every program starts at logical 0
    end else if (hit) begin
      if (kill) begin
        active <= 1'b0;  // exit or translation fault
      end
      if (pc_we) begin
        pc <= pc_wdata;
      end
    end
  end

  always_ff @(posedge clka) begin
    if (launch) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (hit && reg_we) begin
      regs[reg_idx] <= reg_wdata;
    end
  end

endmodule

//--- hw/context_select.sv
module context_select
  import cpu_pkg::*;
(
  input  logic               clka,
  input  logic               rst_n,
  input  logic               start,
  input  logic               advance,
  input  logic [NUM_CTX-1:0] active,
  input  laddr_t             pcs [NUM_CTX],
  input  data_t              regs_all [NUM_CTX][NUM_REGS],
  output ctx_t               cur_ctx,
  output laddr_t             cur_pc,
  output data_t              cur_regs [NUM_REGS],
  output logic               any_active
);

  ctx_t next_ctx;

  // walk from the farthest slot back so the nearest active one after cur wins;
  // cur itself has the lowest priority and is kept only if it is alone
  always_comb begin
    ctx_t cand;
    next_ctx = cur_ctx;
    for (int k = NUM_CTX; k >= 1; k--) begin
      cand = cur_ctx + ctx_t'(k);  // wraps modulo NUM_CTX
      if (active[cand]) begin
        next_ctx = cand;
      end
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      cur_ctx <= '0;
    end else if (start) begin
      cur_ctx <= '0;
    end else if (advance) begin
      cur_ctx <= next_ctx;
    end
  end

  assign cur_pc     = pcs[cur_ctx];
  assign cur_regs   = regs_all[cur_ctx];
  assign any_active = |active;

endmodule

//--- hw/exec_core.sv
module exec_core
  import cpu_pkg::*;
(
  input  logic     clka,
  input  logic     rst_n,
  input  logic     start,
  input  ctx_t     cur_ctx,
  input  laddr_t   cur_pc,
  input  data_t    cur_regs [NUM_REGS],
  input  logic     any_active,
  input  logic     xlate_done,
  input  paddr_t   xlate_paddr,
  input  logic     xlate_fault,
  input  data_t    ram_rdata,
  output logic     xlate_req,
  output ctx_t     xlate_ctx,
  output laddr_t   xlate_laddr,
  output paddr_t   ram_raddr,
  output logic     ram_we,
  output paddr_t   ram_waddr,
  output data_t    ram_wdata,
  output logic     ctx_we,
  output ctx_t     ctx_sel,
  output logic     reg_we,
  output reg_idx_t reg_idx,
  output data_t    reg_wdata,
  output logic     pc_we,
  output laddr_t   pc_wdata,
  output logic     kill,
  output logic     advance,
  output logic     fault,
  output ctx_t     fault_ctx
);

  exec_state_t state;
  exec_state_t state_nxt;
  opcode_t     op_q;
  reg_idx_t    rsel_q;
  data_t       imm_q;
  logic [1:0]  slice_cnt;  // instructions retired in this slice
  logic        switch_q;   // advance owed on the next idle cycle
  logic        load_wait;  // ram2reg data arrives next cycle
  logic        retire;
  logic        xlate_bad;

  assign xlate_bad = xlate_done & xlate_fault;

  always_comb begin
    state_nxt   = state;
    xlate_req   = 1'b0;
    xlate_laddr = cur_pc;
    ram_we      = 1'b0;
    reg_we      = 1'b0;
    reg_wdata   = imm_q;
    pc_we       = 1'b0;
    pc_wdata    = cur_pc + 8'd2;
    kill        = 1'b0;
    fault       = 1'b0;
    retire      = 1'b0;
    case (state)
      IDLE: begin
        if (any_active) state_nxt = XLATE;
      end
      XLATE: begin
        xlate_req = 1'b1;
        state_nxt = READ;
      end
      READ, FETCH_OP: begin
        if (xlate_bad) begin
          kill      = 1'b1;
          fault     = 1'b1;
          state_nxt = IDLE;
        end else if (state == READ) begin
          xlate_req   = 1'b1;  // immediate word, overlapped with opcode read
          xlate_laddr = cur_pc + 8'd1;
          state_nxt   = FETCH_OP;
        end else begin
          state_nxt = FETCH_IMM;
        end
      end
      FETCH_IMM: state_nxt = DECODE;
      DECODE: begin
        case (op_q)
          NUM2REG: begin
            reg_we = 1'b1;
            pc_we  = 1'b1;
            retire = 1'b1;
          end
          REG_PLUS, REG_MINUS: begin
            reg_we    = 1'b1;
            reg_wdata = (op_q == REG_PLUS) ? cur_regs[rsel_q] + imm_q
                                           : cur_regs[rsel_q] - imm_q;  // wraps at 16 bits
            pc_we     = 1'b1;
            retire    = 1'b1;
          end
          JMP: begin
            pc_we    = 1'b1;
            pc_wdata = imm_q[7:0];
            retire   = 1'b1;
          end
          RAM2REG, REG2RAM: begin
            xlate_req   = 1'b1;
            xlate_laddr = imm_q[7:0];
            state_nxt   = (op_q == RAM2REG) ? LOAD_DATA : STORE;
          end
          EXIT: begin
            kill      = 1'b1;
            state_nxt = IDLE;
          end
          default: begin  // unknown opcode is a no-op
            pc_we  = 1'b1;
            retire = 1'b1;
          end
        endcase
      end
      LOAD_DATA: begin
        if (load_wait) begin
          reg_we    = 1'b1;
          reg_wdata = ram_rdata;
          pc_we     = 1'b1;
          retire    = 1'b1;
        end else if (xlate_bad) begin
          kill      = 1'b1;
          fault     = 1'b1;
          state_nxt = IDLE;
        end
      end
      STORE: begin
        if (xlate_bad) begin
          kill      = 1'b1;
          fault     = 1'b1;
          state_nxt = IDLE;
        end else begin
          ram_we = 1'b1;
          pc_we  = 1'b1;
          retire = 1'b1;
        end
      end
      default: state_nxt = IDLE;
    endcase
    if (retire) begin
      state_nxt = (slice_cnt == SLICE_LEN - 1) ? IDLE : XLATE;  // slice used up
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      switch_q  <= 1'b0;
      slice_cnt <= '0;
      load_wait <= 1'b0;
    end else begin
      state     <= state_nxt;
      load_wait <= (state == LOAD_DATA) & ~load_wait & ~xlate_bad;
      if (start) begin
        switch_q <= 1'b1;  // first advance picks the first active slot
      end else if (state == IDLE) begin
        switch_q <= 1'b0;
      end else if (state_nxt == IDLE) begin
        switch_q <= 1'b1;  // exit, fault or end of slice
      end
      if (advance) begin
        slice_cnt <= '0;
      end else if (retire) begin
        slice_cnt <= slice_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clka) begin
    if (state == FETCH_OP) begin
      op_q   <= opcode_t'(ram_rdata[15:8]);
      rsel_q <= ram_rdata[2:0];
    end
    if (state == FETCH_IMM) begin
      imm_q <= ram_rdata;
    end
  end

  // switching happens one cycle after a kill so the slot's active flag is already clear
  assign advance   = (state == IDLE) & switch_q;
  assign xlate_ctx = cur_ctx;
  assign ram_raddr = xlate_paddr;  // every read uses the address translated last cycle
  assign ram_waddr = xlate_paddr;
  assign ram_wdata = cur_regs[rsel_q];
  assign ctx_we    = reg_we | pc_we | kill;
  assign ctx_sel   = cur_ctx;
  assign reg_idx   = rsel_q;
  assign fault_ctx = cur_ctx;

endmodule

//--- hw/cpu_top.sv
module cpu_top
  import cpu_pkg::*;
(
  input  logic               clka,
  input  logic               rst_n,
  input  logic               host_we,
  input  paddr_t             host_addr,
  input  data_t              host_wdata,
  output data_t              host_rdata,
  input  logic               map_we,
  input  ctx_t               map_ctx,
  input  lpage_t             map_lpage,
  input  ppage_t             map_ppage,
  input  logic               start,
  input  logic [NUM_CTX-1:0] start_mask,
  output logic               busy,
  output logic               fault,
  output ctx_t               fault_ctx
);

  logic               xlate_req;
  ctx_t               xlate_ctx;
  laddr_t             xlate_laddr;
  logic               xlate_done;
  paddr_t             xlate_paddr;
  logic               xlate_fault;
  paddr_t             core_raddr;
  logic               core_we;
  paddr_t             core_waddr;
  data_t              core_wdata;
  data_t              ram_rdata;
  logic               ctx_we;
  ctx_t               ctx_sel;
  logic               reg_we;
  reg_idx_t           reg_idx;
  data_t              reg_wdata;
  logic               pc_we;
  laddr_t             pc_wdata;
  logic               kill;
  logic               advance;
  logic [NUM_CTX-1:0] active;
  laddr_t             pcs [NUM_CTX];
  data_t              regs_all [NUM_CTX][NUM_REGS];
  ctx_t               cur_ctx;
  laddr_t             cur_pc;
  data_t              cur_regs [NUM_REGS];

  // host owns the ram while no process runs
  dual_port_ram u_ram (
    .clka  (clka),
    .we    (busy ? core_we : host_we),
    .waddr (busy ? core_waddr : host_addr),
    .wdata (busy ? core_wdata : host_wdata),
    .raddr (busy ? core_raddr : host_addr),
    .rdata (ram_rdata)
  );

  assign host_rdata = ram_rdata;

  mmu_xlate u_mmu (
    .clka        (clka),
    .rst_n       (rst_n),
    .map_we      (map_we),
    .map_ctx     (map_ctx),
    .map_lpage   (map_lpage),
    .map_ppage   (map_ppage),
    .xlate_req   (xlate_req),
    .xlate_ctx   (xlate_ctx),
    .xlate_laddr (xlate_laddr),
    .xlate_done  (xlate_done),
    .xlate_paddr (xlate_paddr),
    .xlate_fault (xlate_fault)
  );

  for (genvar i = 0; i < NUM_CTX; i++) begin : g_ctx
    proc_context #(
      .CTX_ID (i)
    ) u_ctx (
      .clka       (clka),
      .rst_n      (rst_n),
      .start      (start),
      .start_mask (start_mask),
      .ctx_we     (ctx_we),
      .ctx_sel    (ctx_sel),
      .reg_we     (reg_we),
      .reg_idx    (reg_idx),
      .reg_wdata  (reg_wdata),
      .pc_we      (pc_we),
      .pc_wdata   (pc_wdata),
      .kill       (kill),
      .active     (active[i]),
      .pc         (pcs[i]),
      .regs       (regs_all[i])
    );
  end

  context_select u_sel (
    .clka       (clka),
    .rst_n      (rst_n),
    .start      (start),
    .advance    (advance),
    .active     (active),
    .pcs        (pcs),
    .regs_all   (regs_all),
    .cur_ctx    (cur_ctx),
    .cur_pc     (cur_pc),
    .cur_regs   (cur_regs),
    .any_active (busy)
  );

  exec_core u_core (
    .clka        (clka),
    .rst_n       (rst_n),
    .start       (start),
    .cur_ctx     (cur_ctx),
    .cur_pc      (cur_pc),
    .cur_regs    (cur_regs),
    .any_active  (busy),
    .xlate_done  (xlate_done),
    .xlate_paddr (xlate_paddr),
    .xlate_fault (xlate_fault),
    .ram_rdata   (ram_rdata),
    .xlate_req   (xlate_req),
    .xlate_ctx   (xlate_ctx),
    .xlate_laddr (xlate_laddr),
    .ram_raddr   (core_raddr),
    .ram_we      (core_we),
    .ram_waddr   (core_waddr),
    .ram_wdata   (core_wdata),
    .ctx_we      (ctx_we),
    .ctx_sel     (ctx_sel),
    .reg_we      (reg_we),
    .reg_idx     (reg_idx),
    .reg_wdata   (reg_wdata),
    .pc_we       (pc_we),
    .pc_wdata    (pc_wdata),
    .kill        (kill),
    .advance     (advance),
    .fault       (fault),
    .fault_ctx   (fault_ctx)
  );

endmodule

//--- test/cpu_assert.sv
module cpu_assert (
  input logic clka,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic fault,
  input logic core_we
);

  timeunit 1ns;
  timeprecision 100ps;

  // contexts only come alive through a start pulse
  busy_from_start: assert property (@(posedge clka) disable iff (!rst_n)
    $rose(busy) |-> $past(start))
    else $error("busy rose without a start pulse");

  fault_one_cycle: assert property (@(posedge clka) disable iff (!rst_n)
    fault |=> !fault)
    else $error("fault held for more than one cycle");

  fault_while_busy: assert property (@(posedge clka) disable iff (!rst_n)
    fault |-> busy)
    else $error("fault pulse with no active context");

  no_core_write_idle: assert property (@(posedge clka) disable iff (!rst_n)
    !busy |-> !core_we)
    else $error("core wrote ram while busy was low");

endmodule

bind cpu_top cpu_assert u_assert (
  .clka    (clka),
  .rst_n   (rst_n),
  .start   (start),
  .busy    (busy),
  .fault   (fault),
  .core_we (core_we)
);

//--- test/cpu_tb.sv
module cpu_tb
  import cpu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam string PATTERN_FILE     = "test/cpu_patterns.txt";
  localparam int    CYCLES_PER_INSTR = 400;

  logic               clka;
  logic               rst_n;
  logic               host_we;
  paddr_t             host_addr;
  data_t              host_wdata;
  data_t              host_rdata;
  logic               map_we;
  ctx_t               map_ctx;
  lpage_t             map_lpage;
  ppage_t             map_ppage;
  logic               start;
  logic [NUM_CTX-1:0] start_mask;
  logic               busy;
  logic               fault;
  ctx_t               fault_ctx;

  int                 cycle_cnt = 0;
  int                 cycle_limit = 1000000;
  int                 err_cnt = 0;
  int                 pass_cnt = 0;
  int                 fail_cnt = 0;
  int                 fault_cnt [NUM_CTX] = '{default: 0};
  int                 fault_base [NUM_CTX];
  logic [NUM_CTX-1:0] fault_exp;
  string              test_name;
  int                 test_err_base;
  bit                 in_test = 1'b0;

  cpu_top dut0 (
    .clka       (clka),
    .rst_n      (rst_n),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .map_we     (map_we),
    .map_ctx    (map_ctx),
    .map_lpage  (map_lpage),
    .map_ppage  (map_ppage),
    .start      (start),
    .start_mask (start_mask),
    .busy       (busy),
    .fault      (fault),
    .fault_ctx  (fault_ctx)
  );

  initial begin
    clka = 1'b0;
    forever #10 clka = ~clka;
  end

  always @(posedge clka) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the programs did not finish", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // fault pulses per context, sampled mid cycle
  always @(negedge clka) begin
    if (rst_n && fault) begin
      fault_cnt[fault_ctx]++;
    end
  end

  task automatic next_cycle();
    @(posedge clka);
    #2;
  endtask

  task automatic write_word(input paddr_t addr, input data_t data);
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    next_cycle();
    host_we = 1'b0;
  endtask

  task automatic read_word(input paddr_t addr, output data_t data);
    host_addr = addr;
    next_cycle();
    data = host_rdata;  // registered read, held until the next edge
  endtask

  task automatic write_map(input ctx_t c, input lpage_t lp, input ppage_t pp);
    map_we    = 1'b1;
    map_ctx   = c;
    map_lpage = lp;
    map_ppage = pp;
    next_cycle();
    map_we = 1'b0;
  endtask

  task automatic run_program(input logic [NUM_CTX-1:0] mask);
    start      = 1'b1;
    start_mask = mask;
    next_cycle();
    start      = 1'b0;
    start_mask = '0;
    assert (busy) else begin
      $display("busy did not rise after start with mask %h", mask);
      err_cnt++;
    end
    while (busy) begin  // falls once every started context has exited
      next_cycle();
    end
  endtask

  task automatic check_word(input paddr_t addr, input data_t want);
    data_t got;
    read_word(addr, got);
    assert (got == want) else begin
      $display("error at %0d ns: host_rdata at %h is %h, expected %h", $time, addr, got, want);
      err_cnt++;
    end
  endtask

  task automatic close_test();
    int got;
    int want;
    if (in_test) begin
      for (int c = 0; c < NUM_CTX; c++) begin
        got  = fault_cnt[c] - fault_base[c];
        want = fault_exp[c] ? 1 : 0;
        assert (got == want) else begin
          $display("error at %0d ns: fault pulses for context %0d are %0d, expected %0d",
                   $time, c, got, want);
          err_cnt++;
        end
      end
      if (err_cnt == test_err_base) begin
        $display("test %s: pass", test_name);
        pass_cnt++;
      end else begin
        $display("test %s: fail with %0d errors", test_name, err_cnt - test_err_base);
        fail_cnt++;
      end
      in_test = 1'b0;
    end
  endtask

  task automatic open_test(input string name);
    close_test();
    test_name     = name;
    test_err_base = err_cnt;
    fault_exp     = '0;
    for (int c = 0; c < NUM_CTX; c++) begin
      fault_base[c] = fault_cnt[c];
    end
    in_test = 1'b1;
  endtask

  // words loaded by the file, two per instruction, set the run length
  task automatic count_instr(output int n_instr);
    int     fd;
    int     code;
    int     cnt;
    int     n_words;
    paddr_t addr;
    string  tag;
    string  rest;
    n_words = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "W") begin
          code = $fscanf(fd, "%h %d", addr, cnt);
          n_words += cnt;
        end
        code = $fgets(rest, fd);
      end
      $fclose(fd);
    end
    n_instr = n_words / 2;
  endtask

  task automatic run_patterns(input int fd);
    int                 code;
    int                 cnt;
    string              tag;
    string              rest;
    string              name;
    paddr_t             addr;
    data_t              word;
    ctx_t               mctx;
    lpage_t             mlpage;
    ppage_t             mppage;
    logic [NUM_CTX-1:0] mask;
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "T") begin
        code = $fscanf(fd, "%s", name);
        open_test(name);
      end else if (tag == "W") begin
        code = $fscanf(fd, "%h %d", addr, cnt);
        for (int i = 0; i < cnt; i++) begin
          code = $fscanf(fd, "%h", word);
          write_word(addr + paddr_t'(i), word);
        end
      end else if (tag == "M") begin
        code = $fscanf(fd, "%d %d %h", mctx, mlpage, mppage);
        write_map(mctx, mlpage, mppage);
      end else if (tag == "S") begin
        code = $fscanf(fd, "%h", mask);
        run_program(mask);
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h %h", addr, word);
        check_word(addr, word);
      end else if (tag == "F") begin
        code = $fscanf(fd, "%d", mctx);
        fault_exp[mctx] = 1'b1;
      end else begin
        $display("pattern file holds an unknown record type %s", tag);
        err_cnt++;
        code = $fgets(rest, fd);
      end
    end
    close_test();
  endtask

  initial begin
    int fd;
    int n_instr;
    rst_n      = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    map_we     = 1'b0;
    map_ctx    = '0;
    map_lpage  = '0;
    map_ppage  = '0;
    start      = 1'b0;
    start_mask = '0;
    count_instr(n_instr);
    cycle_limit = CYCLES_PER_INSTR * n_instr + 100;  // margin covers reset
    repeat (10) @(posedge clka);
    #2;
    rst_n = 1'b1;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the pattern file %s", PATTERN_FILE);
      err_cnt++;
    end else begin
      run_patterns(fd);
      $fclose(fd);
    end
    $display("%0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- test/cpu_patterns.txt
# records: T name | W paddr count word.. | M ctx lpage ppage | S start_mask | E paddr word | F ctx
# paddr, word, ppage and start_mask in hex; count, ctx and lpage in decimal
T arith
M 0 0 1
M 0 1 2
W 040 10 0401 fff0 0501 0025 0601 0020 0301 0045 1100 0000
W 085 1 dead
S 1
E 085 fff5
T load_store
M 1 0 3
M 1 1 4
W 0c0 8 0202 0050 0502 0101 0302 0051 1100 0000
W 110 2 1234 0000
S 2
E 110 1234
E 111 1335
T isolation
M 2 0 5
M 2 1 6
M 3 0 7
M 3 1 8
W 140 8 0200 0040 0500 0001 0300 0041 1100 0000
W 1c0 8 0200 0040 0500 0001 0300 0041 1100 0000
W 180 2 0100 0000
W 200 2 0200 0000
S c
E 180 0100
E 181 0101
E 200 0200
E 201 0201
T jump
M 0 0 9
M 0 1 a
W 240 10 0403 00aa 0100 0006 0303 0040 0303 0041 1100 0000
W 280 2 5555 0000
S 1
E 280 5555
E 281 00aa
T fault
M 0 0 b
M 0 1 c
M 1 0 d
M 1 1 e
W 2c0 6 0400 0042 0300 0040 1100 0000
W 340 8 0401 0077 0301 0080 0301 0040 1100 0000
W 300 1 0000
W 380 1 1111
S 3
E 300 0042
E 380 1111
F 1
T time_slice
M 0 0 0
M 0 1 f
M 1 0 0
M 1 1 e
M 2 0 0
M 2 1 d
W 000 12 0200 0040 0500 0010 0500 0001 0600 0002 0300 0041 1100 0000
W 3c0 2 1000 0000
W 380 2 2000 0000
W 340 2 3000 0000
S 7
E 3c1 100f
E 381 200f
E 341 300f

//--- all.f
hw/cpu_pkg.sv
hw/dual_port_ram.sv
hw/mmu_xlate.sv
hw/proc_context.sv
hw/context_select.sv
hw/exec_core.sv
hw/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
